// ==== design/addr_check.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "lsq_cfg.svh"

module addr_check (
    input  wire logic                req_valid_i,
    input  wire lsq_pkg::mem_op_e    req_op_i,
    input  wire lsq_pkg::mem_size_e  req_size_i,
    input  wire logic [63:0]         req_addr_i,
    input  wire logic [63:0]         req_data_i,
    input  wire logic [`TAG_W-1:0]   req_tag_i,
    output lsq_pkg::lsq_entry_t      entry_o,
    output logic                     valid_o
);

    logic misaligned;
    logic out_of_window;
    logic is_store;

    assign is_store = (req_op_i == lsq_pkg::STORE);

    // Low address bits must be zero for the access width
    always_comb begin
        unique case (req_size_i)
            lsq_pkg::SIZE_B: misaligned = 1'b0;
            lsq_pkg::SIZE_H: misaligned = req_addr_i[0];
            lsq_pkg::SIZE_W: misaligned = |req_addr_i[1:0];
            lsq_pkg::SIZE_D: misaligned = |req_addr_i[2:0];
            default:         misaligned = 1'b1;
        endcase
    end

    // An aligned access that starts inside the window also ends inside it
    assign out_of_window = (req_addr_i < `MEM_BASE) || (req_addr_i >= `MEM_LIMIT);

    always_comb begin
        entry_o.op   = req_op_i;
        entry_o.size = req_size_i;
        entry_o.addr = req_addr_i;
        entry_o.data = req_data_i;
        entry_o.tag  = req_tag_i;

        if (misaligned) begin
            entry_o.cause = is_store ? lsq_pkg::ST_MISALIGNED : lsq_pkg::LD_MISALIGNED;
        end else if (out_of_window) begin
            entry_o.cause = is_store ? lsq_pkg::ST_ACCESS_FAULT : lsq_pkg::LD_ACCESS_FAULT;
        end else begin
            entry_o.cause = lsq_pkg::XCPT_NONE;
        end
    end

    // Misalignment takes priority over the window check
    assign valid_o = req_valid_i;

endmodule

`default_nettype wire

// ==== design/data_mem.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "lsq_cfg.svh"

module data_mem (
    input  wire logic                 clk_i,
    input  wire logic                 rstn_i,
    input  wire logic                 rd_valid_i,
    input  wire lsq_pkg::lsq_entry_t  rd_entry_i,
    input  wire logic                 wr_valid_i,
    input  wire lsq_pkg::lsq_entry_t  wr_entry_i,
    output logic                      resp_valid_o,
    output logic [`TAG_W-1:0]         resp_tag_o,
    output logic [63:0]               resp_data_o,
    output lsq_pkg::xcpt_cause_e      resp_cause_o
);

    localparam int unsigned WORDS = 128;  // 1 KiB window in double words

    logic [63:0] mem [WORDS];

    logic [63:0] rd_off;
    logic [63:0] wr_off;
    logic [6:0]  rd_idx;
    logic [6:0]  wr_idx;
    logic [7:0]  wr_be;
    logic [63:0] wr_data_sh;
    logic [63:0] rd_sh;
    logic [63:0] rd_ext;

    assign rd_off = rd_entry_i.addr - `MEM_BASE;
    assign wr_off = wr_entry_i.addr - `MEM_BASE;
    assign rd_idx = rd_off[9:3];
    assign wr_idx = wr_off[9:3];

    // Byte lanes of the store
    always_comb begin
        unique case (wr_entry_i.size)
            lsq_pkg::SIZE_B: wr_be = 8'h01 << wr_entry_i.addr[2:0];
            lsq_pkg::SIZE_H: wr_be = 8'h03 << wr_entry_i.addr[2:0];
            lsq_pkg::SIZE_W: wr_be = 8'h0f << wr_entry_i.addr[2:0];
            default:         wr_be = 8'hff;
        endcase
    end

    assign wr_data_sh = wr_entry_i.data << {wr_entry_i.addr[2:0], 3'b000};
    assign rd_sh      = mem[rd_idx] >> {rd_entry_i.addr[2:0], 3'b000};

    always_comb begin
        unique case (rd_entry_i.size)
            lsq_pkg::SIZE_B: rd_ext = {56'b0, rd_sh[7:0]};  // Zero extended
            lsq_pkg::SIZE_H: rd_ext = {48'b0, rd_sh[15:0]};
            lsq_pkg::SIZE_W: rd_ext = {32'b0, rd_sh[31:0]};
            default:         rd_ext = rd_sh;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            resp_valid_o <= 1'b0;
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            resp_valid_o <= rd_valid_i;
            if (wr_valid_i) begin
                for (int b = 0; b < 8; b++) begin
                    if (wr_be[b]) mem[wr_idx][b*8 +: 8] <= wr_data_sh[b*8 +: 8];
                end
            end
        end
    end

    // Response payload, excepting entries return zero data
    always_ff @(posedge clk_i) begin
        if (rd_valid_i) begin
            resp_tag_o   <= rd_entry_i.tag;
            resp_cause_o <= rd_entry_i.cause;
            resp_data_o  <= (rd_entry_i.cause == lsq_pkg::XCPT_NONE) ? rd_ext : 64'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/lsq_cfg.svh ====
`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

// Load/store queue entries
`define LSQ_DEPTH 8

// Uncommitted stores held after leaving the queue
`define SB_DEPTH 4

// Physical memory window, limit is exclusive
`define MEM_BASE 64'h0000_0000_8000_0000
`define MEM_LIMIT 64'h0000_0000_8000_0400

// Instruction tag width
`define TAG_W 6

`endif

// ==== design/lsq_pkg.sv ====
`default_nettype none

`include "lsq_cfg.svh"

package lsq_pkg;

    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } mem_op_e;

    // Access width in bytes is 1 << size
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } mem_size_e;

    typedef enum logic [2:0] {
        XCPT_NONE       = 3'd0,
        LD_MISALIGNED   = 3'd1,
        ST_MISALIGNED   = 3'd2,
        LD_ACCESS_FAULT = 3'd3,
        ST_ACCESS_FAULT = 3'd4
    } xcpt_cause_e;

    // One memory operation as it travels through the queue
    typedef struct packed {
        mem_op_e             op;
        mem_size_e           size;
        logic [63:0]         addr;
        logic [63:0]         data;  // Store data, unused for loads
        logic [`TAG_W-1:0]   tag;
        xcpt_cause_e         cause;
    } lsq_entry_t;

endpackage

`default_nettype wire

// ==== design/lsq_top.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "lsq_cfg.svh"

module lsq_top (
    input  wire logic                clk_i,
    input  wire logic                rstn_i,
    input  wire logic                flush_i,
    input  wire logic                req_valid_i,
    input  wire lsq_pkg::mem_op_e    req_op_i,
    input  wire lsq_pkg::mem_size_e  req_size_i,
    input  wire logic [63:0]         req_addr_i,
    input  wire logic [63:0]         req_data_i,
    input  wire logic [`TAG_W-1:0]   req_tag_i,
    input  wire logic                commit_valid_i,
    input  wire logic [`TAG_W-1:0]   commit_tag_i,
    output logic                     full_o,
    output logic                     empty_o,
    output logic                     resp_valid_o,
    output logic [`TAG_W-1:0]        resp_tag_o,
    output logic [63:0]              resp_data_o,
    output lsq_pkg::xcpt_cause_e     resp_cause_o
);

    lsq_pkg::lsq_entry_t chk_entry;
    lsq_pkg::lsq_entry_t sb_entry;
    lsq_pkg::lsq_entry_t mem_entry;
    lsq_pkg::lsq_entry_t head_entry;
    lsq_pkg::lsq_entry_t sb_wr_entry;

    logic chk_valid;
    logic sb_push;
    logic mem_valid;
    logic sb_wr_valid;
    logic sb_full;
    logic sb_empty;
    logic q_empty;
    logic collision;

    assign empty_o = q_empty && sb_empty;

    addr_check u_addr_check (
        .req_valid_i (req_valid_i),
        .req_op_i    (req_op_i),
        .req_size_i  (req_size_i),
        .req_addr_i  (req_addr_i),
        .req_data_i  (req_data_i),
        .req_tag_i   (req_tag_i),
        .entry_o     (chk_entry),
        .valid_o     (chk_valid)
    );

    mem_queue #(.DEPTH(`LSQ_DEPTH), .entry_t(lsq_pkg::lsq_entry_t)) u_mem_queue (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .wr_valid_i    (chk_valid),
        .wr_entry_i    (chk_entry),
        .sb_full_i     (sb_full),
        .collision_i   (collision),
        .sb_push_o     (sb_push),
        .sb_entry_o    (sb_entry),
        .issue_valid_o (mem_valid),
        .issue_entry_o (mem_entry),
        .head_entry_o  (head_entry),
        .full_o        (full_o),
        .empty_o       (q_empty)
    );

    store_buffer #(.DEPTH(`SB_DEPTH), .entry_t(lsq_pkg::lsq_entry_t)) u_store_buffer (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .push_i         (sb_push),
        .push_entry_i   (sb_entry),
        .commit_valid_i (commit_valid_i),
        .commit_tag_i   (commit_tag_i),
        .load_entry_i   (head_entry),
        .wr_valid_o     (sb_wr_valid),
        .wr_entry_o     (sb_wr_entry),
        .full_o         (sb_full),
        .empty_o        (sb_empty),
        .collision_o    (collision)
    );

    data_mem u_data_mem (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .rd_valid_i   (mem_valid),
        .rd_entry_i   (mem_entry),
        .wr_valid_i   (sb_wr_valid),
        .wr_entry_i   (sb_wr_entry),
        .resp_valid_o (resp_valid_o),
        .resp_tag_o   (resp_tag_o),
        .resp_data_o  (resp_data_o),
        .resp_cause_o (resp_cause_o)
    );

endmodule

`default_nettype wire

// ==== design/mem_queue.sv ====
`default_nettype none
`timescale 1ns/1ns

module mem_queue #(
    parameter int unsigned DEPTH   = 8,
    parameter type         entry_t = lsq_pkg::lsq_entry_t
) (
    input  wire logic    clk_i,
    input  wire logic    rstn_i,
    input  wire logic    flush_i,

    // From the address checker
    input  wire logic    wr_valid_i,
    input  wire entry_t  wr_entry_i,

    // Store buffer status
    input  wire logic    sb_full_i,
    input  wire logic    collision_i,

    output logic         sb_push_o,
    output entry_t       sb_entry_o,

    // Load and exception issue towards memory
    output logic         issue_valid_o,
    output entry_t       issue_entry_o,

    output entry_t       head_entry_o,  // Collision check input of the store buffer
    output logic         full_o,
    output logic         empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = PTR_W + 1;

    entry_t ring_q [DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;  // One bit wider than the pointers

    logic   push;
    logic   pop;
    logic   head_vld;
    entry_t head_entry;

    assign full_o   = (count == CNT_W'(DEPTH));
    assign empty_o  = (count == '0);
    assign head_vld = !empty_o;

    // Writes are dropped while full
    assign push = wr_valid_i && !full_o;

    assign head_entry = ring_q[head];

    // Head steering
    always_comb begin
        sb_push_o     = 1'b0;
        issue_valid_o = 1'b0;
        if (head_vld && !flush_i) begin
            if (head_entry.cause != lsq_pkg::XCPT_NONE) begin
                issue_valid_o = 1'b1;            // Exceptions never wait
            end else if (head_entry.op == lsq_pkg::STORE) begin
                sb_push_o = !sb_full_i;
            end else begin
                issue_valid_o = !collision_i;    // Load waits on older buffered store
            end
        end
    end

    assign pop = sb_push_o || issue_valid_o;

    assign sb_entry_o    = head_entry;
    assign issue_entry_o = head_entry;
    assign head_entry_o  = head_entry;

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            ring_q[tail] <= wr_entry_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

`default_nettype wire

// ==== design/store_buffer.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "lsq_cfg.svh"

module store_buffer #(
    parameter int unsigned DEPTH   = 4,
    parameter type         entry_t = lsq_pkg::lsq_entry_t
) (
    input  wire logic               clk_i,
    input  wire logic               rstn_i,
    input  wire logic               flush_i,

    input  wire logic               push_i,
    input  wire entry_t             push_entry_i,

    // Commit acknowledge from the core
    input  wire logic               commit_valid_i,
    input  wire logic [`TAG_W-1:0]  commit_tag_i,

    input  wire entry_t             load_entry_i,  // Current queue head

    output logic                    wr_valid_o,
    output entry_t                  wr_entry_o,
    output logic                    full_o,
    output logic                    empty_o,
    output logic                    collision_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    entry_t sb_q [DEPTH];

    logic [DEPTH-1:0] vld;
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;

    logic push;

    assign full_o  = &vld;
    assign empty_o = ~|vld;

    assign push = push_i && !full_o;

    // Oldest store drains once its tag is committed
    assign wr_entry_o = sb_q[head];
    assign wr_valid_o = commit_valid_i && !empty_o && !flush_i &&
                        (sb_q[head].tag == commit_tag_i);

    // Double word overlap of the head load against every buffered store
    always_comb begin
        collision_o = 1'b0;
        if (load_entry_i.op == lsq_pkg::LOAD) begin
            for (int i = 0; i < DEPTH; i++) begin
                if (vld[i] && (sb_q[i].addr[63:3] == load_entry_i.addr[63:3])) begin
                    collision_o = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            sb_q[tail] <= push_entry_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vld  <= '0;
            head <= '0;
            tail <= '0;
        end else if (flush_i) begin
            vld  <= '0;   // Uncommitted stores are dropped
            head <= '0;
            tail <= '0;
        end else begin
            if (push) begin
                vld[tail] <= 1'b1;
                tail <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (wr_valid_o) begin
                vld[head] <= 1'b0;
                head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/lsq_pkg.sv
design/addr_check.sv
design/mem_queue.sv
design/store_buffer.sv
design/data_mem.sv
design/lsq_top.sv
sim/lsq_tb.sv

// ==== sim/lsq_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "lsq_cfg.svh"

module lsq_tb;

    localparam int TIMEOUT = 200;  // Cycles allowed for any single wait

    logic clk_i, rstn_i, flush_i, req_valid_i, commit_valid_i;
    logic full_o, empty_o, resp_valid_o;
    lsq_pkg::mem_op_e     req_op_i;
    lsq_pkg::mem_size_e   req_size_i;
    logic [63:0]          req_addr_i, req_data_i, resp_data_o;
    logic [`TAG_W-1:0]    req_tag_i, commit_tag_i, resp_tag_o;
    lsq_pkg::xcpt_cause_e resp_cause_o;

    // Stimulus table with the expected cause of each row
    string                r_name [32];
    lsq_pkg::mem_op_e     r_op [32];
    lsq_pkg::mem_size_e   r_size [32];
    logic [63:0]          r_addr [32], r_data [32];
    logic [`TAG_W-1:0]    r_tag [32];
    bit                   r_commit [32];
    lsq_pkg::xcpt_cause_e r_cause [32];
    int                   n_rows;

    logic [7:0]           ref_mem [1024];  // Expected byte image of the window
    logic [`TAG_W-1:0]    rsp_tag_q [$];
    logic [63:0]          rsp_data_q [$];
    lsq_pkg::xcpt_cause_e rsp_cause_q [$];
    integer               seed;
    int                   errors, checks;

    lsq_top dut (.*);

    always #20 clk_i = ~clk_i;

    // Responses captured mid cycle
    always @(negedge clk_i) begin
        if (rstn_i && resp_valid_o) begin
            rsp_tag_q.push_back(resp_tag_o);
            rsp_data_q.push_back(resp_data_o);
            rsp_cause_q.push_back(resp_cause_o);
        end
    end

    task automatic compare(string name, string field, logic [63:0] exp, logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", name, field, exp, act);
        end
    endtask

    task automatic add_row(string name, lsq_pkg::mem_op_e op, lsq_pkg::mem_size_e size,
                           logic [63:0] addr, logic [63:0] data, logic [`TAG_W-1:0] tag,
                           bit commit, lsq_pkg::xcpt_cause_e cause);
        r_name[n_rows]   = name;
        r_op[n_rows]     = op;
        r_size[n_rows]   = size;
        r_addr[n_rows]   = addr;
        r_data[n_rows]   = data;
        r_tag[n_rows]    = tag;
        r_commit[n_rows] = commit;
        r_cause[n_rows]  = cause;
        n_rows++;
    endtask

    task automatic send_req(lsq_pkg::mem_op_e op, lsq_pkg::mem_size_e size,
                            logic [63:0] addr, logic [63:0] data, logic [`TAG_W-1:0] tag);
        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_op_i    <= op;
        req_size_i  <= size;
        req_addr_i  <= addr;
        req_data_i  <= data;
        req_tag_i   <= tag;
    endtask

    task automatic end_req();
        @(posedge clk_i);
        req_valid_i <= 1'b0;
    endtask

    task automatic set_commit(bit valid, logic [`TAG_W-1:0] tag);
        @(posedge clk_i);
        commit_valid_i <= valid;
        commit_tag_i   <= tag;
    endtask

    // Waits for full_o or empty_o
    task automatic wait_level(bit want_full, string name);
        int cnt;
        cnt = 0;
        @(negedge clk_i);
        while ((want_full ? !full_o : !empty_o) && cnt < TIMEOUT) begin
            @(negedge clk_i);
            cnt++;
        end
        if (want_full ? !full_o : !empty_o) begin
            errors++;
            $display("Timeout in %s: the unit never became %s", name,
                     want_full ? "full" : "empty");
        end
    endtask

    task automatic expect_resp(string name, logic [`TAG_W-1:0] tag, logic [63:0] data,
                               lsq_pkg::xcpt_cause_e cause);
        int cnt;
        cnt = 0;
        while (rsp_tag_q.size() == 0 && cnt < TIMEOUT) begin
            @(posedge clk_i);
            cnt++;
        end
        if (rsp_tag_q.size() == 0) begin
            errors++;
            $display("Timeout in %s: no response arrived", name);
        end else begin
            compare(name, "tag", 64'(tag), 64'(rsp_tag_q.pop_front()));
            compare(name, "data", data, rsp_data_q.pop_front());
            compare(name, "cause", 64'(cause), 64'(rsp_cause_q.pop_front()));
        end
    endtask

    task automatic apply_store(logic [63:0] addr, lsq_pkg::mem_size_e size, logic [63:0] data);
        for (int b = 0; b < (1 << size); b++) begin
            ref_mem[int'(addr - `MEM_BASE) + b] = data[8*b +: 8];
        end
    endtask

    function automatic logic [63:0] ref_load(logic [63:0] addr, lsq_pkg::mem_size_e size);
        logic [63:0] v;
        v = '0;  // Loads zero extend
        for (int b = 0; b < (1 << size); b++) begin
            v[8*b +: 8] = ref_mem[int'(addr - `MEM_BASE) + b];
        end
        return v;
    endfunction

    // Commit is held until everything has drained
    task automatic commit_store(string name, logic [`TAG_W-1:0] tag, logic [63:0] addr,
                                lsq_pkg::mem_size_e size, logic [63:0] data);
        set_commit(1'b1, tag);
        wait_level(1'b0, name);
        set_commit(1'b0, tag);
        apply_store(addr, size, data);
    endtask

    task automatic run_table();
        for (int i = 0; i < n_rows; i++) begin
            send_req(r_op[i], r_size[i], r_addr[i], r_data[i], r_tag[i]);
            end_req();
            if (r_cause[i] != lsq_pkg::XCPT_NONE) begin
                expect_resp(r_name[i], r_tag[i], 64'h0, r_cause[i]);
            end else if (r_op[i] == lsq_pkg::STORE) begin
                if (r_commit[i]) begin
                    commit_store(r_name[i], r_tag[i], r_addr[i], r_size[i], r_data[i]);
                end
            end else begin
                expect_resp(r_name[i], r_tag[i], ref_load(r_addr[i], r_size[i]),
                            lsq_pkg::XCPT_NONE);
            end
        end
    endtask

    task automatic hold_on_collision();
        logic [63:0] d;
        d = {$random(seed), $random(seed)};
        send_req(lsq_pkg::STORE, lsq_pkg::SIZE_D, 64'h8000_0100, d, 6'h20);
        send_req(lsq_pkg::LOAD, lsq_pkg::SIZE_W, 64'h8000_0104, 64'h0, 6'h21);
        end_req();
        repeat (10) @(posedge clk_i);  // Load stays parked behind the store
        checks++;
        assert (rsp_tag_q.size() == 0) else begin
            errors++;
            $display("Fail collision_hold: expected 0, actual %0d", rsp_tag_q.size());
        end
        commit_store("collision", 6'h20, 64'h8000_0100, lsq_pkg::SIZE_D, d);
        expect_resp("collision_ld", 6'h21, ref_load(64'h8000_0104, lsq_pkg::SIZE_W),
                    lsq_pkg::XCPT_NONE);
    endtask

    task automatic fill_queue();
        logic [63:0] d;
        d = {$random(seed), $random(seed)};
        send_req(lsq_pkg::STORE, lsq_pkg::SIZE_D, 64'h8000_0180, d, 6'h28);
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            send_req(lsq_pkg::LOAD, lsq_pkg::SIZE_B, 64'h8000_0180 + i, 64'h0, 6'h30 + i);
        end
        end_req();
        wait_level(1'b1, "full");
        commit_store("full", 6'h28, 64'h8000_0180, lsq_pkg::SIZE_D, d);
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            expect_resp($sformatf("full_ld%0d", i), 6'h30 + i,
                        ref_load(64'h8000_0180 + i, lsq_pkg::SIZE_B), lsq_pkg::XCPT_NONE);
        end
    endtask

    task automatic flush_stores();
        send_req(lsq_pkg::STORE, lsq_pkg::SIZE_D, 64'h8000_0200, {$random(seed), $random(seed)},
                 6'h38);
        send_req(lsq_pkg::STORE, lsq_pkg::SIZE_W, 64'h8000_020c, {$random(seed), $random(seed)},
                 6'h39);
        end_req();
        repeat (4) @(negedge clk_i);
        checks++;
        assert (!empty_o) else begin
            errors++;
            $display("The uncommitted stores were not held before the flush");
        end
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        wait_level(1'b0, "flush");
        send_req(lsq_pkg::LOAD, lsq_pkg::SIZE_D, 64'h8000_0200, 64'h0, 6'h3a);
        send_req(lsq_pkg::LOAD, lsq_pkg::SIZE_W, 64'h8000_020c, 64'h0, 6'h3b);
        end_req();
        expect_resp("flush_ld0", 6'h3a, ref_load(64'h8000_0200, lsq_pkg::SIZE_D),
                    lsq_pkg::XCPT_NONE);
        expect_resp("flush_ld1", 6'h3b, ref_load(64'h8000_020c, lsq_pkg::SIZE_W),
                    lsq_pkg::XCPT_NONE);
    endtask

    initial begin
        clk_i          = 1'b0;
        rstn_i         = 1'b0;
        flush_i        = 1'b0;
        req_valid_i    = 1'b0;
        req_op_i       = lsq_pkg::LOAD;
        req_size_i     = lsq_pkg::SIZE_B;
        req_addr_i     = '0;
        req_data_i     = '0;
        req_tag_i      = '0;
        commit_valid_i = 1'b0;
        commit_tag_i   = '0;
        seed           = 5620;
        errors         = 0;
        checks         = 0;
        n_rows         = 0;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = 8'h00;  // Memory comes out of reset cleared
        end

        add_row("st_byte", lsq_pkg::STORE, lsq_pkg::SIZE_B, 64'h8000_0011,
                {$random(seed), $random(seed)}, 6'h01, 1'b1, lsq_pkg::XCPT_NONE);
        add_row("ld_byte", lsq_pkg::LOAD, lsq_pkg::SIZE_B, 64'h8000_0011, 64'h0, 6'h02,
                1'b0, lsq_pkg::XCPT_NONE);
        add_row("st_half", lsq_pkg::STORE, lsq_pkg::SIZE_H, 64'h8000_0022,
                {$random(seed), $random(seed)}, 6'h03, 1'b1, lsq_pkg::XCPT_NONE);
        add_row("ld_half", lsq_pkg::LOAD, lsq_pkg::SIZE_H, 64'h8000_0022, 64'h0, 6'h04,
                1'b0, lsq_pkg::XCPT_NONE);
        add_row("st_word", lsq_pkg::STORE, lsq_pkg::SIZE_W, 64'h8000_0034,
                {$random(seed), $random(seed)}, 6'h05, 1'b1, lsq_pkg::XCPT_NONE);
        add_row("ld_word", lsq_pkg::LOAD, lsq_pkg::SIZE_W, 64'h8000_0034, 64'h0, 6'h06,
                1'b0, lsq_pkg::XCPT_NONE);
        add_row("st_dbl", lsq_pkg::STORE, lsq_pkg::SIZE_D, 64'h8000_0048,
                {$random(seed), $random(seed)}, 6'h07, 1'b1, lsq_pkg::XCPT_NONE);
        add_row("ld_dbl", lsq_pkg::LOAD, lsq_pkg::SIZE_D, 64'h8000_0048, 64'h0, 6'h08,
                1'b0, lsq_pkg::XCPT_NONE);
        // Excepting rows alias the double word of st_dbl, so nonzero data would show
        add_row("ld_misal", lsq_pkg::LOAD, lsq_pkg::SIZE_W, 64'h8000_004a, 64'h0, 6'h09,
                1'b0, lsq_pkg::LD_MISALIGNED);
        add_row("st_misal", lsq_pkg::STORE, lsq_pkg::SIZE_D, 64'h8000_004c,
                {$random(seed), $random(seed)}, 6'h0a, 1'b1, lsq_pkg::ST_MISALIGNED);
        add_row("ld_after_misal", lsq_pkg::LOAD, lsq_pkg::SIZE_D, 64'h8000_0048, 64'h0, 6'h0b,
                1'b0, lsq_pkg::XCPT_NONE);
        add_row("ld_fault", lsq_pkg::LOAD, lsq_pkg::SIZE_D, 64'h7fff_fc48, 64'h0, 6'h0c,
                1'b0, lsq_pkg::LD_ACCESS_FAULT);
        add_row("st_fault", lsq_pkg::STORE, lsq_pkg::SIZE_W, 64'h8000_0448,
                {$random(seed), $random(seed)}, 6'h0d, 1'b1, lsq_pkg::ST_ACCESS_FAULT);
        add_row("ld_after_fault", lsq_pkg::LOAD, lsq_pkg::SIZE_D, 64'h8000_0048, 64'h0, 6'h0e,
                1'b0, lsq_pkg::XCPT_NONE);
        add_row("st_old0", lsq_pkg::STORE, lsq_pkg::SIZE_D, 64'h8000_0200,
                {$random(seed), $random(seed)}, 6'h0f, 1'b1, lsq_pkg::XCPT_NONE);
        add_row("st_old1", lsq_pkg::STORE, lsq_pkg::SIZE_D, 64'h8000_0208,
                {$random(seed), $random(seed)}, 6'h10, 1'b1, lsq_pkg::XCPT_NONE);

        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;

        run_table();
        hold_on_collision();
        fill_queue();
        flush_stores();

        repeat (2) @(posedge clk_i);
        checks++;
        assert (rsp_tag_q.size() == 0) else begin
            errors++;
            $display("Fail leftover_responses: expected 0, actual %0d", rsp_tag_q.size());
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
